// ==== logic/exu_macros.svh ====
`ifndef EXU_MACROS_SVH
`define EXU_MACROS_SVH

////////////////////////////////////////////////////////////////////////////
// datapath widths
////////////////////////////////////////////////////////////////////////////

// data and byte address width of the core
`define XLEN 32

// register index width, 32 architectural registers
`define REG_ADDR_W 5

////////////////////////////////////////////////////////////////////////////
// memory and reset
////////////////////////////////////////////////////////////////////////////

// words in the data RAM, indexed by address bits above the byte offset
`define DMEM_DEPTH 64

// level of rst that holds the pipeline in reset
`define RST_ENABLE 1'b0

`endif

// ==== logic/exu_pkg.sv ====
`default_nettype none

`include "exu_macros.svh"

package exu_pkg;

  typedef logic [`XLEN-1:0]       word_t;
  typedef logic [`XLEN-1:0]       addr_t;
  typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [31:0]            inst_t;  // RV32 instructions are always 32 bits

  typedef enum logic [2:0] {
    INST_NONE,
    INST_ALU_R,
    INST_ALU_I,
    INST_LUI,
    INST_LOAD,
    INST_STORE
  } inst_type_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLL,
    ALU_SRL,
    ALU_PASS_B
  } alu_op_e;

  typedef enum logic [1:0] {
    LSU_NONE,
    LSU_LW,
    LSU_SW
  } lsu_op_e;

  //////////////////////////////////////////////////////////////////////////
  // stage records
  //////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    inst_type_e inst_type;
    alu_op_e    alu_op;
    lsu_op_e    lsu_op;
    logic       wsel;       // writeback takes the load data
    logic       wena;
    reg_addr_t  waddr;
    addr_t      pc;
    word_t      imm;
    word_t      rdata1;
    word_t      rdata2;
    logic       valid;
  } id_ex_t;

  typedef struct packed {
    logic      valid;
    lsu_op_e   lsu_op;
    logic      wsel;
    logic      wena;
    reg_addr_t waddr;
    addr_t     pc;
    word_t     result;      // ALU result, or the byte address for memory ops
    word_t     store_data;
  } ex_mem_t;

  typedef struct packed {
    logic      valid;
    reg_addr_t waddr;
    word_t     data;
  } wb_t;

endpackage

`default_nettype wire

// ==== logic/exu_regfile.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "exu_macros.svh"

module exu_regfile import exu_pkg::*; (
  input  wire logic clk,
  input  wire logic rst,

  input  reg_addr_t raddr1_i,
  input  reg_addr_t raddr2_i,
  output word_t     rdata1_o,
  output word_t     rdata2_o,

  input  wb_t       wb_i
);

  word_t regs [1:31];  // x0 has no storage

  always_ff @(posedge clk or negedge rst) begin
    if (rst == `RST_ENABLE) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_i.valid && wb_i.waddr != '0) begin
      regs[wb_i.waddr] <= wb_i.data;
    end
  end

  // a read of the register being written this cycle sees the new value
  always_comb begin
    if (raddr1_i == '0) begin
      rdata1_o = '0;
    end else if (wb_i.valid && wb_i.waddr == raddr1_i) begin
      rdata1_o = wb_i.data;
    end else begin
      rdata1_o = regs[raddr1_i];
    end

    if (raddr2_i == '0) begin
      rdata2_o = '0;
    end else if (wb_i.valid && wb_i.waddr == raddr2_i) begin
      rdata2_o = wb_i.data;
    end else begin
      rdata2_o = regs[raddr2_i];
    end
  end

endmodule

`default_nettype wire

// ==== logic/exu_decode.sv ====
`timescale 1ns/10ps
`default_nettype none

module exu_decode import exu_pkg::*; (
  input  wire logic inst_valid_i,
  input  inst_t     inst_i,
  input  addr_t     pc_i,

  output reg_addr_t raddr1_o,
  output reg_addr_t raddr2_o,
  input  word_t     rdata1_i,
  input  word_t     rdata2_i,

  output id_ex_t    id_o
);

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  reg_addr_t  rd;
  inst_type_e itype;
  alu_op_e    aop;

  assign opcode   = inst_i[6:0];
  assign rd       = inst_i[11:7];
  assign funct3   = inst_i[14:12];
  assign funct7   = inst_i[31:25];
  assign raddr1_o = inst_i[19:15];
  assign raddr2_o = inst_i[24:20];

  ////////////////////////////////////////////////////////////////////////////
  // instruction class and ALU function
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    itype = INST_NONE;
    aop   = ALU_ADD;
    if (inst_valid_i) begin
      case (opcode)
        OPC_OP: begin
          itype = INST_ALU_R;
          case ({funct7, funct3})
            10'b0000000_000: aop = ALU_ADD;
            10'b0100000_000: aop = ALU_SUB;
            10'b0000000_111: aop = ALU_AND;
            10'b0000000_110: aop = ALU_OR;
            10'b0000000_100: aop = ALU_XOR;
            10'b0000000_010: aop = ALU_SLT;
            10'b0000000_001: aop = ALU_SLL;
            10'b0000000_101: aop = ALU_SRL;
            default:         itype = INST_NONE;
          endcase
        end
        OPC_OP_IMM: begin
          itype = INST_ALU_I;
          case (funct3)
            3'b000:  aop = ALU_ADD;
            3'b111:  aop = ALU_AND;
            3'b110:  aop = ALU_OR;
            3'b100:  aop = ALU_XOR;
            3'b010:  aop = ALU_SLT;
            default: itype = INST_NONE;  // immediate shifts are not supported
          endcase
        end
        OPC_LUI: begin
          itype = INST_LUI;
          aop   = ALU_PASS_B;
        end
        OPC_LOAD:  if (funct3 == 3'b010) itype = INST_LOAD;   // LW only
        OPC_STORE: if (funct3 == 3'b010) itype = INST_STORE;  // SW only
        default:   itype = INST_NONE;
      endcase
    end
  end

  always_comb begin
    id_o           = '0;
    id_o.inst_type = itype;
    id_o.alu_op    = aop;
    id_o.lsu_op    = (itype == INST_LOAD)  ? LSU_LW :
                     (itype == INST_STORE) ? LSU_SW : LSU_NONE;
    id_o.wsel      = (itype == INST_LOAD);
    id_o.wena      = (itype inside {INST_ALU_R, INST_ALU_I, INST_LUI, INST_LOAD}) && (rd != '0);
    id_o.waddr     = rd;
    id_o.pc        = pc_i;
    id_o.rdata1    = rdata1_i;
    id_o.rdata2    = rdata2_i;
    id_o.valid     = (itype != INST_NONE);
    case (itype)
      INST_STORE: id_o.imm = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
      INST_LUI:   id_o.imm = {inst_i[31:12], 12'b0};
      default:    id_o.imm = {{20{inst_i[31]}}, inst_i[31:20]};
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/exu_id_ex_reg.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "exu_macros.svh"

module exu_id_ex_reg import exu_pkg::*; (
  input  wire logic clk,
  input  wire logic rst,

  input  wire logic stall_i,  // hold the record and issue a bubble
  input  id_ex_t    id_i,
  output id_ex_t    id_o
);

  ////////////////////////////////////////////////////////////////////////////
  // decoded instruction bank
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst) begin
    if (rst == `RST_ENABLE) begin
      id_o <= '0;
    end else if (!stall_i) begin
      id_o <= id_i;
    end else begin
      // fields keep their value so the held instruction stays visible,
      // only valid drops so it does not run twice
      id_o.valid <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== logic/exu_alu.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "exu_macros.svh"

module exu_alu import exu_pkg::*; (
  input  wire logic clk,
  input  wire logic rst,

  input  id_ex_t    id_i,
  output ex_mem_t   ex_o
);

  word_t op_b;
  word_t alu_res;
  word_t addr_sum;

  assign op_b     = (id_i.inst_type == INST_ALU_R) ? id_i.rdata2 : id_i.imm;
  assign addr_sum = id_i.rdata1 + id_i.imm;  // byte address for LW and SW

  ////////////////////////////////////////////////////////////////////////////
  // ALU
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (id_i.alu_op)
      ALU_ADD:    alu_res = id_i.rdata1 + op_b;
      ALU_SUB:    alu_res = id_i.rdata1 - op_b;
      ALU_AND:    alu_res = id_i.rdata1 & op_b;
      ALU_OR:     alu_res = id_i.rdata1 | op_b;
      ALU_XOR:    alu_res = id_i.rdata1 ^ op_b;
      ALU_SLT:    alu_res = {{(`XLEN-1){1'b0}}, $signed(id_i.rdata1) < $signed(op_b)};
      ALU_SLL:    alu_res = id_i.rdata1 << op_b[4:0];
      ALU_SRL:    alu_res = id_i.rdata1 >> op_b[4:0];
      ALU_PASS_B: alu_res = op_b;  // LUI
      default:    alu_res = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // EX/MEM register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst) begin
    if (rst == `RST_ENABLE) begin
      ex_o <= '0;
    end else begin
      ex_o.valid      <= id_i.valid;
      ex_o.lsu_op     <= id_i.lsu_op;
      ex_o.wsel       <= id_i.wsel;
      ex_o.wena       <= id_i.wena;
      ex_o.waddr      <= id_i.waddr;
      ex_o.pc         <= id_i.pc;
      ex_o.result     <= (id_i.lsu_op != LSU_NONE) ? addr_sum : alu_res;
      ex_o.store_data <= id_i.rdata2;
    end
  end

endmodule

`default_nettype wire

// ==== logic/exu_lsu.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "exu_macros.svh"

module exu_lsu import exu_pkg::*; (
  input  wire logic clk,
  input  wire logic rst,

  input  ex_mem_t   ex_i,
  output wb_t       wb_o
);

  localparam int IDX_W = $clog2(`DMEM_DEPTH);

  word_t            dmem [`DMEM_DEPTH];
  logic [IDX_W-1:0] widx;
  logic             store_en;
  word_t            load_data;

  assign widx     = ex_i.result[IDX_W+1:2];  // word index, byte offset dropped
  assign store_en = ex_i.valid && (ex_i.lsu_op == LSU_SW);

  ////////////////////////////////////////////////////////////////////////////
  // data RAM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst) begin
    if (rst == `RST_ENABLE) begin
      for (int i = 0; i < `DMEM_DEPTH; i++) begin
        dmem[i] <= '0;
      end
    end else if (store_en) begin
      dmem[widx] <= ex_i.store_data;
    end
  end

  assign load_data = dmem[widx];  // asynchronous read

  ////////////////////////////////////////////////////////////////////////////
  // writeback select
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    wb_o.valid = ex_i.valid && ex_i.wena;
    wb_o.waddr = ex_i.waddr;
    wb_o.data  = ex_i.wsel ? load_data : ex_i.result;
  end

endmodule

`default_nettype wire

// ==== logic/exu_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module exu_top import exu_pkg::*; (
  input  wire logic clk,
  input  wire logic rst,

  input  wire logic inst_valid_i,
  input  inst_t     inst_i,
  input  addr_t     pc_i,
  input  wire logic stall_i,

  output logic      wb_valid_o,
  output reg_addr_t wb_addr_o,
  output word_t     wb_data_o,
  output addr_t     wb_pc_o
);

  reg_addr_t raddr1;
  reg_addr_t raddr2;
  word_t     rdata1;
  word_t     rdata2;
  id_ex_t    id_dec;
  id_ex_t    id_ex;
  ex_mem_t   ex_mem;
  wb_t       wb;

  exu_decode u_decode (
    .inst_valid_i (inst_valid_i),
    .inst_i       (inst_i),
    .pc_i         (pc_i),
    .raddr1_o     (raddr1),
    .raddr2_o     (raddr2),
    .rdata1_i     (rdata1),
    .rdata2_i     (rdata2),
    .id_o         (id_dec)
  );

  exu_regfile u_regfile (
    .clk      (clk),
    .rst      (rst),
    .raddr1_i (raddr1),
    .raddr2_i (raddr2),
    .rdata1_o (rdata1),
    .rdata2_o (rdata2),
    .wb_i     (wb)
  );

  exu_id_ex_reg u_id_ex_reg (
    .clk     (clk),
    .rst     (rst),
    .stall_i (stall_i),
    .id_i    (id_dec),
    .id_o    (id_ex)
  );

  exu_alu u_alu (
    .clk  (clk),
    .rst  (rst),
    .id_i (id_ex),
    .ex_o (ex_mem)
  );

  exu_lsu u_lsu (
    .clk  (clk),
    .rst  (rst),
    .ex_i (ex_mem),
    .wb_o (wb)
  );

  assign wb_valid_o = wb.valid;
  assign wb_addr_o  = wb.waddr;
  assign wb_data_o  = wb.data;
  assign wb_pc_o    = ex_mem.pc;  // the writeback record carries no pc, trace it from EX/MEM

endmodule

`default_nettype wire

// ==== test/exu_assertions.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "exu_macros.svh"

module exu_assertions import exu_pkg::*; (
  input wire logic clk,
  input wire logic rst,
  input wire logic stall_i,
  input wire logic wb_valid_i,
  input reg_addr_t wb_addr_i
);

  // all pipeline registers are cleared, so nothing may retire in reset
  wb_quiet_in_reset: assert property (
    @(posedge clk) (rst == `RST_ENABLE) |-> !wb_valid_i
  ) else $error("writeback valid while in reset");

  wb_addr_nonzero: assert property (
    @(posedge clk) disable iff (rst == `RST_ENABLE) wb_valid_i |-> (wb_addr_i != '0)
  ) else $error("writeback to x0");

  // a stalled edge leaves a bubble that reaches writeback two edges later
  stall_makes_bubble: assert property (
    @(posedge clk) disable iff (rst == `RST_ENABLE) stall_i |-> ##2 !wb_valid_i
  ) else $error("writeback two edges after a stall");

endmodule

bind exu_top exu_assertions u_assertions (
  .clk        (clk),
  .rst        (rst),
  .stall_i    (stall_i),
  .wb_valid_i (wb_valid_o),
  .wb_addr_i  (wb_addr_o)
);

`default_nettype wire

// ==== test/exu_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module exu_tb import exu_pkg::*; ();

  localparam int          CLK_HALF   = 10;
  localparam int          RST_CYCLES = 5;
  localparam logic [31:0] SEED       = 32'h992d3326;

  typedef struct packed {
    logic  valid;
    addr_t pc;
    inst_t inst;
  } stim_t;

  typedef struct packed {
    addr_t     pc;
    reg_addr_t waddr;
    word_t     data;
  } wb_exp_t;

  logic      clk;
  logic      rst;
  logic      inst_valid;
  inst_t     inst;
  addr_t     pc;
  logic      stall;
  logic      wb_valid;
  reg_addr_t wb_addr;
  word_t     wb_data;
  addr_t     wb_pc;

  stim_t   stim_q[$];
  wb_exp_t exp_q[$];
  int      burst_q[$];  // stall edges in front of each trace instruction
  int      cycle_count;
  int      cycle_limit;

  exu_top uut (
    .clk          (clk),
    .rst          (rst),
    .inst_valid_i (inst_valid),
    .inst_i       (inst),
    .pc_i         (pc),
    .stall_i      (stall),
    .wb_valid_o   (wb_valid),
    .wb_addr_o    (wb_addr),
    .wb_data_o    (wb_data),
    .wb_pc_o      (wb_pc)
  );

  always #CLK_HALF clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // trace file and checking
  ////////////////////////////////////////////////////////////////////////////

  task automatic load_trace(output int n_lines);
    int            fd;
    int            n;
    logic [63:0]   kind;
    logic [1023:0] rest;
    logic [31:0]   f1;
    logic [31:0]   f2;
    logic [31:0]   f3;
    n_lines = 0;
    fd = $fopen("test/exu_trace.txt", "r");
    if (fd == 0) begin
      $display("could not open test/exu_trace.txt");
      $display("TESTS FAILED");
      $fatal(1, "no trace file");
    end
    while (!$feof(fd)) begin
      n = $fscanf(fd, "%s", kind);
      if (n != 1) break;
      if (kind == "#") begin
        n = $fgets(rest, fd);
      end else begin
        n = $fscanf(fd, "%h %h %h", f1, f2, f3);
        if (kind == "i") stim_q.push_back({f1[0], f2, f3});
        else exp_q.push_back({f1, f2[4:0], f3});  // expected writeback line
        n_lines++;
      end
    end
    $fclose(fd);
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      $display("** Error at %0t: %s is %h, expected %h", $time, what, got, expected);
      $display("TESTS FAILED");
      $fatal(1, "mismatch on %s", what);
    end
  endtask

  // outputs are combinational from the EX/MEM register and settle before the falling edge
  always @(negedge clk) begin
    if (rst && wb_valid) begin
      if (exp_q.size() == 0) begin
        $display("unexpected writeback to x%0d at %0t", wb_addr, $time);
        $display("TESTS FAILED");
        $fatal(1, "extra writeback");
      end else begin
        check_value("writeback pc", wb_pc, exp_q[0].pc);
        check_value("writeback register", 32'(wb_addr), 32'(exp_q[0].waddr));
        check_value("writeback data", wb_data, exp_q[0].data);
        void'(exp_q.pop_front());
      end
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      $display("run timed out after %0d cycles", cycle_count);
      $display("TESTS FAILED");
      $fatal(1, "timeout");
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int n_lines;
    int stall_total;
    int seed_ret;
    clk         = 1'b0;
    rst         = 1'b0;
    inst_valid  = 1'b0;
    inst        = '0;
    pc          = '0;
    stall       = 1'b0;
    cycle_count = 0;
    seed_ret    = $urandom(SEED);
    load_trace(n_lines);
    stall_total = 0;
    foreach (stim_q[k]) begin
      burst_q.push_back(int'($urandom % 4));
      stall_total += burst_q[k];
    end
    cycle_limit = 4 * (n_lines + stall_total) + 20;

    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b1;
    foreach (stim_q[k]) begin
      inst_valid <= stim_q[k].valid;  // held steady through the stall burst
      inst       <= stim_q[k].inst;
      pc         <= stim_q[k].pc;
      stall      <= (burst_q[k] != 0);
      repeat (burst_q[k]) @(posedge clk);
      stall <= 1'b0;
      @(posedge clk);
    end
    inst_valid <= 1'b0;

    // the last writeback shows one cycle after its accepting edge
    repeat (4) @(posedge clk);
    if (exp_q.size() == 0) begin
      $display("TESTS PASSED");
      $finish;
    end else begin
      $display("%0d expected writebacks never arrived", exp_q.size());
      $display("TESTS FAILED");
      $fatal(1, "missing writebacks");
    end
  end

endmodule

`default_nettype wire

// ==== exu_pipe.f ====
+incdir+logic
logic/exu_pkg.sv
logic/exu_regfile.sv
logic/exu_decode.sv
logic/exu_id_ex_reg.sv
logic/exu_alu.sv
logic/exu_lsu.sv
logic/exu_top.sv
test/exu_assertions.sv
test/exu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, then search the log for the fail message
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -f exu_pipe.f --top-module exu_tb -o exu_sim \
  > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/exu_sim > sim.log 2>&1
cat sim.log
grep -q "TESTS FAILED" sim.log && exit 1
grep -q "TESTS PASSED" sim.log || exit 1
exit 0

// ==== test/exu_trace.txt ====
# i <valid> <pc> <instruction>    instruction word presented to the pipeline
# e <pc> <rd> <data>              writeback expected from the instruction at pc
i 1 00000000 00500093
e 00000000 01 00000005
i 1 00000004 ffd00113
e 00000004 02 fffffffd
i 1 00000008 800001b7
e 00000008 03 80000000
i 1 0000000c 01a08213
e 0000000c 04 0000001f
i 1 00000010 002082b3
e 00000010 05 00000002
i 1 00000014 40110333
e 00000014 06 fffffff8
i 1 00000018 001123b3
e 00000018 07 00000001
i 1 0000001c 00409433
e 0000001c 08 80000000
i 1 00000020 002154b3
e 00000020 09 00000007
i 1 00000024 00117533
e 00000024 0a 00000005
i 1 00000028 0011e5b3
e 00000028 0b 80000005
i 1 0000002c 00114633
e 0000002c 0c fffffff8
i 1 00000030 0f017693
e 00000030 0d 000000f0
i 1 00000034 ff00e713
e 00000034 0e fffffff5
i 1 00000038 fff14793
e 00000038 0f 00000002
i 1 0000003c 00012813
e 0000003c 10 00000001
i 1 00000040 04b02023
i 1 00000044 00708013
i 0 00000048 00100893
i 1 0000004c 00309913
i 1 00000050 04002983
e 00000050 13 80000005
i 1 00000054 08002a03
e 00000054 14 00000000
